// File: rv_ex_macros.svh
`ifndef RV_EX_MACROS_SVH
`define RV_EX_MACROS_SVH

// datapath width
`define RV_EX_XLEN 32

// register index width and register count
`define RV_EX_REG_W 5
`define RV_EX_NREGS 32

`endif

// File: rv_ex_pkg.sv
`default_nettype none

`include "rv_ex_macros.svh"

package rv_ex_pkg;

	typedef logic [`RV_EX_XLEN-1:0] data_t;
	typedef logic [`RV_EX_REG_W-1:0] reg_idx_t;

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} instr_t;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		B     = 7'b1100011,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		MEM   = 7'b0001111,
		SYS   = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} alu_op_e;

	typedef logic [1:0] fwd_sel_t;
	localparam fwd_sel_t FWD_RS  = 2'b00;
	localparam fwd_sel_t FWD_EX  = 2'b10;
	localparam fwd_sel_t FWD_MEM = 2'b11;

	typedef logic [1:0] opnd_sel_t;
	localparam opnd_sel_t SEL_ZERO   = 2'b00;
	localparam opnd_sel_t SEL_REG    = 2'b10;
	localparam opnd_sel_t SEL_PC_IMM = 2'b11;

	localparam data_t ZERO = '0;

endpackage

`default_nettype wire

// File: rv_ex_ifs.sv
`default_nettype none

// decoded instruction from decode to execute
interface dec_ex_if;
	import rv_ex_pkg::*;

	logic     valid;
	logic     ready;
	data_t    pc;
	data_t    imm;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	opcode_e  opcode;
	alu_op_e  alu_op;
	logic     we;

	modport src (output valid, pc, imm, rs1, rs2, rd, opcode, alu_op, we, input ready);
	modport dst (input valid, pc, imm, rs1, rs2, rd, opcode, alu_op, we, output ready);

endinterface

// computed result from execute to writeback
interface ex_wb_if;
	import rv_ex_pkg::*;

	logic     valid;
	logic     ready;
	data_t    pc;
	reg_idx_t rd;
	logic     we;
	data_t    result;

	modport src (output valid, pc, rd, we, result, input ready);
	modport dst (input valid, pc, rd, we, result, output ready);

endinterface

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
	input  rv_ex_pkg::alu_op_e op,
	input  rv_ex_pkg::data_t   a,
	input  rv_ex_pkg::data_t   b,
	output rv_ex_pkg::data_t   result
);
	import rv_ex_pkg::*;

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = data_t'(lt_s);
			ALU_SLTU: result = data_t'(lt_u);
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = data_t'($signed(a) >>> shamt);
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			ALU_EQ:   result = data_t'(a == b);
			ALU_NE:   result = data_t'(a != b);
			ALU_LT:   result = data_t'(lt_s);
			ALU_GE:   result = data_t'(!lt_s);
			ALU_LTU:  result = data_t'(lt_u);
			ALU_GEU:  result = data_t'(!lt_u);
			default:  result = ZERO;
		endcase
	end

endmodule

`default_nettype wire

// File: forward_unit.sv
`default_nettype none

module forward_unit (
	input  rv_ex_pkg::opcode_e  opcode,
	input  rv_ex_pkg::reg_idx_t rs1,
	input  rv_ex_pkg::reg_idx_t rs2,
	input  wire                 ex_valid,
	input  wire                 ex_we,
	input  rv_ex_pkg::reg_idx_t ex_rd,
	input  wire                 mem_valid,
	input  wire                 mem_we,
	input  rv_ex_pkg::reg_idx_t mem_rd,
	output rv_ex_pkg::fwd_sel_t fwd_a,
	output rv_ex_pkg::fwd_sel_t fwd_b
);
	import rv_ex_pkg::*;

	logic uses_rs1;
	logic uses_rs2;

	// younger producer wins
	function automatic fwd_sel_t pick(input logic used, input reg_idx_t rs);
		if (!used || rs == '0) begin
			return FWD_RS;
		end
		if (ex_valid && ex_we && ex_rd == rs) begin
			return FWD_EX;
		end
		if (mem_valid && mem_we && mem_rd == rs) begin
			return FWD_MEM;
		end
		return FWD_RS;
	endfunction

	assign uses_rs1 = opcode inside {R, I, B, LOAD, STORE};
	assign uses_rs2 = opcode inside {R, B};

	assign fwd_a = pick(uses_rs1, rs1);
	assign fwd_b = pick(uses_rs2, rs2);

endmodule

`default_nettype wire

// File: ex_mux.sv
`default_nettype none

module ex_mux (
	input  rv_ex_pkg::opcode_e  opcode,
	input  rv_ex_pkg::data_t    pc,
	input  rv_ex_pkg::data_t    rs1,
	input  rv_ex_pkg::data_t    rs2,
	input  rv_ex_pkg::data_t    imm,
	input  rv_ex_pkg::data_t    ex_ex_fwd_data,
	input  rv_ex_pkg::data_t    mem_ex_fwd_data,
	input  rv_ex_pkg::fwd_sel_t fwd_a,
	input  rv_ex_pkg::fwd_sel_t fwd_b,
	output rv_ex_pkg::data_t    a_out,
	output rv_ex_pkg::data_t    b_out
);
	import rv_ex_pkg::*;

	opnd_sel_t a_sel;
	opnd_sel_t b_sel;

	function automatic data_t pick_src(input opnd_sel_t sel, input data_t rs, input data_t alt);
		case (sel)
			SEL_REG:    return rs;
			SEL_PC_IMM: return alt;
			default:    return ZERO;
		endcase
	endfunction

	function automatic data_t pick_fwd(input fwd_sel_t sel, input data_t src);
		case (sel)
			FWD_EX:  return ex_ex_fwd_data;
			FWD_MEM: return mem_ex_fwd_data;
			default: return src;
		endcase
	endfunction

	always_comb begin
		a_sel = SEL_ZERO;
		b_sel = SEL_ZERO;
		case (opcode)
			R, B: begin
				a_sel = SEL_REG;
				b_sel = SEL_REG;
			end
			I, LOAD, STORE: begin // rs1 + imm
				a_sel = SEL_REG;
				b_sel = SEL_PC_IMM;
			end
			LUI:               b_sel = SEL_PC_IMM; // 0 + imm
			AUIPC, JAL, JALR: begin // pc + imm
				a_sel = SEL_PC_IMM;
				b_sel = SEL_PC_IMM;
			end
			default: ; // MEM, SYS and unknown see zeros
		endcase
	end

	assign a_out = pick_fwd(fwd_a, pick_src(a_sel, rs1, pc));
	assign b_out = pick_fwd(fwd_b, pick_src(b_sel, rs2, imm));

endmodule

`default_nettype wire

// File: decode_stage.sv
`default_nettype none

module decode_stage (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 in_valid,
	output logic                in_ready,
	input  rv_ex_pkg::instr_t   in_instr,
	input  rv_ex_pkg::data_t    in_pc,
	dec_ex_if.src               dec
);
	import rv_ex_pkg::*;

	opcode_e op;
	data_t   imm_d;
	alu_op_e alu_d;
	logic    we_d;

	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	function automatic alu_op_e branch_op(input logic [2:0] f3);
		case (f3)
			3'b000:  return ALU_EQ;
			3'b001:  return ALU_NE;
			3'b100:  return ALU_LT;
			3'b101:  return ALU_GE;
			3'b110:  return ALU_LTU;
			3'b111:  return ALU_GEU;
			default: return ALU_ADD; // reserved funct3
		endcase
	endfunction

	assign op       = opcode_e'(in_instr.opcode);
	assign in_ready = !dec.valid || dec.ready;

	always_comb begin
		imm_d = ZERO;
		alu_d = ALU_ADD;
		we_d  = 1'b0;
		case (op)
			R: begin
				alu_d = arith_op(in_instr.funct3, in_instr.funct7[5]);
				we_d  = 1'b1;
			end
			I: begin
				imm_d = {{20{in_instr[31]}}, in_instr[31:20]};
				alu_d = arith_op(in_instr.funct3,
					in_instr.funct3 == 3'b101 && in_instr.funct7[5]); // srai only
				we_d  = 1'b1;
			end
			B: begin
				imm_d = {{19{in_instr[31]}}, in_instr[31], in_instr[7], in_instr[30:25],
					in_instr[11:8], 1'b0};
				alu_d = branch_op(in_instr.funct3);
			end
			LUI, AUIPC: begin
				imm_d = {in_instr[31:12], 12'b0};
				we_d  = 1'b1;
			end
			JAL, JALR: begin
				imm_d = 32'd4; // link value is pc + 4
				we_d  = 1'b1;
			end
			LOAD:    imm_d = {{20{in_instr[31]}}, in_instr[31:20]};
			STORE:   imm_d = {{20{in_instr[31]}}, in_instr[31:25], in_instr[11:7]};
			default: ;
		endcase
		we_d = we_d && (in_instr.rd != '0);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec.valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			dec.valid <= 1'b1;
		end else if (dec.ready) begin
			dec.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			dec.pc     <= in_pc;
			dec.imm    <= imm_d;
			dec.rs1    <= in_instr.rs1;
			dec.rs2    <= in_instr.rs2;
			dec.rd     <= in_instr.rd;
			dec.opcode <= op;
			dec.alu_op <= alu_d;
			dec.we     <= we_d;
		end
	end

	a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid && !dec.ready |=> dec.valid && $stable({dec.pc, dec.imm, dec.rs1,
			dec.rs2, dec.rd, dec.opcode, dec.alu_op, dec.we}));

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

`include "rv_ex_macros.svh"

module reg_file (
	input  wire                 clk,
	input  wire                 rst_n,
	input  rv_ex_pkg::reg_idx_t rd_addr_a,
	input  rv_ex_pkg::reg_idx_t rd_addr_b,
	output rv_ex_pkg::data_t    rd_data_a,
	output rv_ex_pkg::data_t    rd_data_b,
	input  wire                 wr_en,
	input  rv_ex_pkg::reg_idx_t wr_addr,
	input  rv_ex_pkg::data_t    wr_data
);
	import rv_ex_pkg::*;

	data_t regs [`RV_EX_NREGS];
	logic  wr_live;

	assign wr_live = wr_en && (wr_addr != '0); // x0 is never written

	function automatic data_t read_port(input reg_idx_t addr);
		return (wr_live && wr_addr == addr) ? wr_data : regs[addr];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_EX_NREGS; i++) begin
				regs[i] <= ZERO;
			end
		end else if (wr_live) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd_data_a = read_port(rd_addr_a);
	assign rd_data_b = read_port(rd_addr_b);

	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_addr_a == '0 |-> rd_data_a == ZERO) and (rd_addr_b == '0 |-> rd_data_b == ZERO));

endmodule

`default_nettype wire

// File: execute_stage.sv
`default_nettype none

module execute_stage (
	input  wire                 clk,
	input  wire                 rst_n,
	dec_ex_if.dst               dec,
	ex_wb_if.src                exo,
	output rv_ex_pkg::reg_idx_t rf_addr_a,
	output rv_ex_pkg::reg_idx_t rf_addr_b,
	input  rv_ex_pkg::data_t    rf_data_a,
	input  rv_ex_pkg::data_t    rf_data_b,
	input  wire                 mem_valid,
	input  wire                 mem_we,
	input  rv_ex_pkg::reg_idx_t mem_rd,
	input  rv_ex_pkg::data_t    mem_result
);
	import rv_ex_pkg::*;

	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	data_t    opnd_a;
	data_t    opnd_b;
	data_t    alu_res;

	assign rf_addr_a = dec.rs1;
	assign rf_addr_b = dec.rs2;
	assign dec.ready = !exo.valid || exo.ready;

	forward_unit u_forward_unit (
		.opcode    (dec.opcode),
		.rs1       (dec.rs1),
		.rs2       (dec.rs2),
		.ex_valid  (exo.valid), // own slot is the ex forward source
		.ex_we     (exo.we),
		.ex_rd     (exo.rd),
		.mem_valid (mem_valid),
		.mem_we    (mem_we),
		.mem_rd    (mem_rd),
		.fwd_a     (fwd_a),
		.fwd_b     (fwd_b)
	);

	ex_mux u_ex_mux (
		.opcode          (dec.opcode),
		.pc              (dec.pc),
		.rs1             (rf_data_a),
		.rs2             (rf_data_b),
		.imm             (dec.imm),
		.ex_ex_fwd_data  (exo.result),
		.mem_ex_fwd_data (mem_result),
		.fwd_a           (fwd_a),
		.fwd_b           (fwd_b),
		.a_out           (opnd_a),
		.b_out           (opnd_b)
	);

	alu u_alu (
		.op     (dec.alu_op),
		.a      (opnd_a),
		.b      (opnd_b),
		.result (alu_res)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exo.valid <= 1'b0;
		end else if (dec.valid && dec.ready) begin
			exo.valid <= 1'b1;
		end else if (exo.ready) begin
			exo.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (dec.valid && dec.ready) begin
			exo.pc     <= dec.pc;
			exo.rd     <= dec.rd;
			exo.we     <= dec.we;
			exo.result <= alu_res;
		end
	end

	a_no_ex_fwd_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!exo.valid |-> (fwd_a != FWD_EX) && (fwd_b != FWD_EX));

endmodule

`default_nettype wire

// File: wb_stage.sv
`default_nettype none

module wb_stage (
	input  wire                 clk,
	input  wire                 rst_n,
	ex_wb_if.dst                exi,
	output logic                res_valid,
	input  wire                 res_ready,
	output rv_ex_pkg::data_t    res_pc,
	output rv_ex_pkg::reg_idx_t res_rd,
	output logic                res_we,
	output rv_ex_pkg::data_t    res_data,
	output logic                rf_wr_en,
	output rv_ex_pkg::reg_idx_t rf_wr_addr,
	output rv_ex_pkg::data_t    rf_wr_data,
	output logic                mem_valid,
	output logic                mem_we,
	output rv_ex_pkg::reg_idx_t mem_rd,
	output rv_ex_pkg::data_t    mem_result
);
	import rv_ex_pkg::*;

	assign exi.ready = !res_valid || res_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else if (exi.valid && exi.ready) begin
			res_valid <= 1'b1;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (exi.valid && exi.ready) begin
			res_pc   <= exi.pc;
			res_rd   <= exi.rd;
			res_we   <= exi.we;
			res_data <= exi.result;
		end
	end

	// commit happens on the output handshake
	assign rf_wr_en   = res_valid && res_ready && res_we;
	assign rf_wr_addr = res_rd;
	assign rf_wr_data = res_data;

	assign mem_valid  = res_valid;
	assign mem_we     = res_we;
	assign mem_rd     = res_rd;
	assign mem_result = res_data;

	a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid);

endmodule

`default_nettype wire

// File: rv_ex_top.sv
`default_nettype none

module rv_ex_top (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 in_valid,
	output logic                in_ready,
	input  rv_ex_pkg::instr_t   in_instr,
	input  rv_ex_pkg::data_t    in_pc,
	output logic                res_valid,
	input  wire                 res_ready,
	output rv_ex_pkg::data_t    res_pc,
	output rv_ex_pkg::reg_idx_t res_rd,
	output logic                res_we,
	output rv_ex_pkg::data_t    res_data
);
	import rv_ex_pkg::*;

	reg_idx_t rf_addr_a;
	reg_idx_t rf_addr_b;
	data_t    rf_data_a;
	data_t    rf_data_b;
	logic     rf_wr_en;
	reg_idx_t rf_wr_addr;
	data_t    rf_wr_data;

	logic     mem_valid; // writeback slot snoop
	logic     mem_we;
	reg_idx_t mem_rd;
	data_t    mem_result;

	dec_ex_if u_dec_ex_if ();
	ex_wb_if  u_ex_wb_if ();

	decode_stage u_decode_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_instr (in_instr),
		.in_pc    (in_pc),
		.dec      (u_dec_ex_if)
	);

	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (rf_addr_a),
		.rd_addr_b (rf_addr_b),
		.rd_data_a (rf_data_a),
		.rd_data_b (rf_data_b),
		.wr_en     (rf_wr_en),
		.wr_addr   (rf_wr_addr),
		.wr_data   (rf_wr_data)
	);

	execute_stage u_execute_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.dec        (u_dec_ex_if),
		.exo        (u_ex_wb_if),
		.rf_addr_a  (rf_addr_a),
		.rf_addr_b  (rf_addr_b),
		.rf_data_a  (rf_data_a),
		.rf_data_b  (rf_data_b),
		.mem_valid  (mem_valid),
		.mem_we     (mem_we),
		.mem_rd     (mem_rd),
		.mem_result (mem_result)
	);

	wb_stage u_wb_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.exi        (u_ex_wb_if),
		.res_valid  (res_valid),
		.res_ready  (res_ready),
		.res_pc     (res_pc),
		.res_rd     (res_rd),
		.res_we     (res_we),
		.res_data   (res_data),
		.rf_wr_en   (rf_wr_en),
		.rf_wr_addr (rf_wr_addr),
		.rf_wr_data (rf_wr_data),
		.mem_valid  (mem_valid),
		.mem_we     (mem_we),
		.mem_rd     (mem_rd),
		.mem_result (mem_result)
	);

endmodule

`default_nettype wire

// File: tb_rv_ex.sv
`default_nettype none

module tb_rv_ex;
	timeunit 1ns;
	timeprecision 100ps;

	import rv_ex_pkg::*;

	localparam logic [31:0] SEED = 32'h5a90_38f2;
	localparam int N_CHAIN = 40;
	localparam int N_UPPER = 27; // 24 random plus 3 fixed x0 cases
	localparam int N_NOWR  = 24;
	localparam int N_RAND  = 200;
	localparam int WATCHDOG_CYCLES = (N_CHAIN + N_UPPER + N_NOWR + N_RAND) * 40 + 200;

	typedef enum int {
		K_R, K_I, K_LUI, K_AUIPC, K_JAL, K_JALR,
		K_B, K_LOAD, K_STORE, K_MEM, K_SYS, K_UNK
	} kind_e;

	typedef struct packed {
		data_t    pc;
		reg_idx_t rd;
		logic     we;
		data_t    data;
	} expect_t;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     in_valid;
	logic     in_ready;
	instr_t   in_instr;
	data_t    in_pc;
	logic     res_valid;
	logic     res_ready;
	data_t    res_pc;
	reg_idx_t res_rd;
	logic     res_we;
	data_t    res_data;

	logic [31:0] rng_state;
	data_t       mregs [32]; // architectural registers of the model
	expect_t     exp_q [$];
	data_t       pc_next;
	int          stall_pct;
	string       test_name;
	int          test_results = 0;
	int          test_errors = 0;
	int          n_tests = 0;
	int          n_results = 0;
	int          n_errors = 0;

	rv_ex_top u_rv_ex_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_instr  (in_instr),
		.in_pc     (in_pc),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res_pc    (res_pc),
		.res_rd    (res_rd),
		.res_we    (res_we),
		.res_data  (res_data)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [15:0] rand16();
		rng_state = lcg_next(rng_state);
		return rng_state[31:16]; // upper half since the low bits of an lcg are weak
	endfunction

	// mostly x0..x7 so that instructions depend on each other
	function automatic reg_idx_t pick_reg();
		logic [15:0] r;
		r = rand16();
		return (r[15:13] == 3'b000) ? r[4:0] : {2'b00, r[2:0]};
	endfunction

	function automatic logic [31:0] encode(input logic [6:0] f7, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic data_t alu_model(input logic [2:0] f3, input logic alt, input data_t a,
		input data_t b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return {31'b0, $signed(a) < $signed(b)};
			3'b011:  return {31'b0, a < b};
			3'b100:  return a ^ b;
			3'b101:  return alt ? data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_model(input logic [2:0] f3, input data_t a, input data_t b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	// executes one instruction in program order and updates the model registers
	function automatic expect_t run_model(input logic [31:0] w, input data_t pc);
		expect_t    e;
		data_t      a;
		data_t      b;
		data_t      imm_i;
		data_t      imm_s;
		data_t      imm_u;
		logic [2:0] f3;
		a     = mregs[w[19:15]];
		b     = mregs[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_u = {w[31:12], 12'h000};
		f3    = w[14:12];
		e.pc   = pc;
		e.rd   = w[11:7];
		e.we   = 1'b0;
		e.data = ZERO;
		case (w[6:0])
			R: begin
				e.data = alu_model(f3, w[30], a, b);
				e.we   = 1'b1;
			end
			I: begin
				e.data = alu_model(f3, f3 == 3'b101 && w[30], a, imm_i);
				e.we   = 1'b1;
			end
			LUI, AUIPC: begin
				e.data = (w[6:0] == LUI) ? imm_u : pc + imm_u;
				e.we   = 1'b1;
			end
			JAL, JALR: begin
				e.data = pc + 32'd4;
				e.we   = 1'b1;
			end
			B:       e.data = {31'b0, branch_model(f3, a, b)};
			LOAD:    e.data = a + imm_i;
			STORE:   e.data = a + imm_s;
			default: ; // fence, system and unknown give zero
		endcase
		e.we = e.we && (e.rd != 5'd0);
		if (e.we) begin
			mregs[e.rd] = e.data;
		end
		return e;
	endfunction

	function automatic logic [31:0] rand_instr(input int kind, input reg_idx_t rd,
		input reg_idx_t rs1, input reg_idx_t rs2);
		logic [15:0] r;
		logic [15:0] q;
		logic [6:0]  f7;
		logic [2:0]  f3;
		r  = rand16();
		q  = rand16();
		f7 = r[15:9];
		f3 = r[2:0];
		case (kind)
			K_R: begin
				f7 = (r[4] && f3 inside {3'd0, 3'd5}) ? 7'h20 : 7'h00;
				return encode(f7, rs2, rs1, f3, rd, R);
			end
			K_I: begin
				if (f3 == 3'b001) begin
					f7 = 7'h00;
				end else if (f3 == 3'b101) begin
					f7 = r[4] ? 7'h20 : 7'h00;
				end
				return encode(f7, q[4:0], rs1, f3, rd, I);
			end
			K_LUI:   return encode(f7, q[4:0], q[9:5], q[12:10], rd, LUI);
			K_AUIPC: return encode(f7, q[4:0], q[9:5], q[12:10], rd, AUIPC);
			K_JAL:   return encode(f7, q[4:0], q[9:5], q[12:10], rd, JAL);
			K_JALR:  return encode(f7, q[4:0], rs1, 3'b000, rd, JALR);
			K_B: begin
				f3 = (r[2:1] == 2'b01) ? {2'b00, r[0]} : r[2:0]; // skip reserved compares
				return encode(f7, rs2, rs1, f3, q[4:0], B);
			end
			K_LOAD:  return encode(f7, q[4:0], rs1, 3'b010, rd, LOAD);
			K_STORE: return encode(f7, rs2, rs1, 3'b010, q[4:0], STORE);
			K_MEM:   return 32'h0ff0_000f;
			K_SYS:   return r[0] ? 32'h0010_0073 : 32'h0000_0073;
			default: return encode(f7, q[4:0], rs1, f3, rd, 7'b0001011);
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
			test_errors++;
			n_errors++;
		end
	endtask

	task automatic check_result();
		expect_t e;
		if (exp_q.size() == 0) begin
			$display("ERROR: %s got a result for pc %h with no instruction outstanding",
				test_name, res_pc);
			test_errors++;
			n_errors++;
		end else begin
			e = exp_q.pop_front();
			check_value("pc", e.pc, res_pc);
			check_value("rd", 32'(e.rd), 32'(res_rd));
			check_value("we", 32'(e.we), 32'(res_we));
			check_value("data", e.data, res_data);
			test_results++;
			n_results++;
		end
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			if (in_valid && in_ready) begin
				exp_q.push_back(run_model(in_instr, in_pc));
			end
			if (res_valid && res_ready) begin
				check_result();
			end
		end
	end

	task automatic update_ready();
		logic [15:0] r;
		r = rand16();
		res_ready = (stall_pct == 0) || ((r % 100) >= stall_pct);
	endtask

	// called just after a falling edge and returns after the transfer
	task automatic send_instr(input logic [31:0] w);
		logic accepted;
		accepted = 1'b0;
		in_valid = 1'b1;
		in_instr = instr_t'(w);
		in_pc    = pc_next;
		pc_next  = pc_next + 32'd4;
		while (!accepted) begin
			@(posedge clk);
			accepted = in_ready;
			@(negedge clk);
			update_ready();
		end
		in_valid = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		in_valid = 1'b0;
		repeat (n) begin
			@(negedge clk);
			update_ready();
		end
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			@(negedge clk);
			update_ready();
		end
		stall_pct = 0;
		idle_cycles(4); // a stray extra result would show up here
	endtask

	task automatic start_test(input string name);
		test_name    = name;
		test_results = 0;
		test_errors  = 0;
	endtask

	task automatic finish_test();
		n_tests++;
		$display("test %-11s %0d results checked, %0d errors", test_name, test_results,
			test_errors);
	endtask

	task automatic run_chain();
		logic [15:0] r;
		reg_idx_t    rd;
		reg_idx_t    prev;
		reg_idx_t    prev2;
		start_test("alu_chain");
		prev  = '0;
		prev2 = '0;
		for (int i = 0; i < N_CHAIN; i++) begin
			r  = rand16();
			rd = (r[2:0] == 3'b000) ? 5'd1 : {2'b00, r[2:0]};
			send_instr(rand_instr(r[3] ? K_R : K_I, rd, prev, prev2)); // ex and mem forward
			prev2 = prev;
			prev  = rd;
		end
		drain();
		finish_test();
	endtask

	task automatic run_upper_jump();
		logic [15:0] r;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		int          kind;
		start_test("upper_jump");
		for (int i = 0; i < N_UPPER - 3; i++) begin
			r    = rand16();
			rd   = pick_reg();
			rs1  = pick_reg();
			rs2  = pick_reg();
			kind = (r[2:1] == 2'b11) ? K_R : K_LUI + int'(r[1:0]);
			send_instr(rand_instr(kind, rd, rs1, rs2));
		end
		send_instr(encode(7'h55, 5'h0a, 5'h13, 3'b101, 5'd0, LUI));
		send_instr(encode(7'h00, 5'd0, 5'd0, 3'b000, 5'd6, I));
		send_instr(encode(7'h00, 5'd0, 5'd0, 3'b000, 5'd5, R));
		drain();
		finish_test();
	endtask

	task automatic run_no_write();
		logic [15:0] r;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		int          kind;
		start_test("no_write");
		for (int i = 0; i < N_NOWR; i++) begin
			r    = rand16();
			rd   = pick_reg();
			rs1  = pick_reg();
			rs2  = pick_reg();
			kind = (r[3:2] == 2'b11) ? K_I : K_B + int'(r[15:8] % 6);
			send_instr(rand_instr(kind, rd, rs1, rs2));
		end
		drain();
		finish_test();
	endtask

	task automatic run_random_flow();
		logic [15:0] r;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		int          kind;
		start_test("random_flow");
		stall_pct = 30;
		for (int i = 0; i < N_RAND; i++) begin
			r = rand16();
			if (r[1:0] == 2'b00) begin
				idle_cycles(1 + int'(r[3:2]));
			end
			rd   = pick_reg();
			rs1  = pick_reg();
			rs2  = pick_reg();
			kind = r[4] ? (r[5] ? K_R : K_I) : int'(r[15:8] % 12);
			send_instr(rand_instr(kind, rd, rs1, rs2));
		end
		drain();
		finish_test();
	endtask

	initial begin
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_instr  = '0;
		in_pc     = ZERO;
		res_ready = 1'b1;
		rng_state = SEED;
		pc_next   = 32'h7fff_ff00; // crosses the sign boundary
		stall_pct = 0;
		test_name = "none";
		for (int i = 0; i < 32; i++) begin
			mregs[i] = ZERO;
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		start_test("reset");
		check_value("res_valid", 32'd0, 32'(res_valid));
		check_value("in_ready", 32'd1, 32'(in_ready));
		finish_test();

		run_chain();
		run_upper_jump();
		run_no_write();
		run_random_flow();

		$display("summary: %0d tests, %0d results, %0d errors", n_tests, n_results, n_errors);
		if (n_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles, the pipeline stopped making progress",
			WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rv_ex.f
+incdir+.
rv_ex_pkg.sv
rv_ex_ifs.sv
alu.sv
forward_unit.sv
ex_mux.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
wb_stage.sv
rv_ex_top.sv
tb_rv_ex.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= rv_ex.f
TB_TOP    ?= tb_rv_ex
RTL_TOP   ?= rv_ex_top
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)
